//--- logic/bk_pkg.sv
/*
 Backup RAM geometry shared by the whole subsystem.
 The RAM is fixed at 64 sectors of 512 bytes; changing the widths
 here changes the save-file size the host must provide.
*/

package bk_pkg;

	// ====================
	// Geometry
	// ====================
	localparam int unsigned bk_sector_bits = 6;   // 64 sectors
	localparam int unsigned bk_offset_bits = 9;   // 512 bytes each
	localparam int unsigned bk_addr_bits   = bk_sector_bits + bk_offset_bits;

	localparam int unsigned bk_last_sector = (2 ** bk_sector_bits) - 1;

	// ====================
	// Types
	// ====================
	typedef logic [7:0] bk_byte_t;

	// Same 15-bit word, two readings.
	// Console side sees a flat byte address,
	// host side sees the sector it is moving and the offset inside it
	typedef union packed {
		logic [bk_addr_bits-1:0] flat;
		struct packed {
			logic [bk_sector_bits-1:0] sector;  // Upper bits
			logic [bk_offset_bits-1:0] offset;  // Lower bits
		} host;
	} bk_addr_u;

endpackage

//--- logic/bk_sector_counter.sv
/*
 Sector index for the current transfer.
 clear wins over advance; the index wraps silently past the last
 sector, so the sequencer must stop on last.
*/

module bk_sector_counter (
	input  logic                              clk_sys,
	input  logic                              rst_n,
	input  logic                              clear,
	input  logic                              advance,
	output logic [bk_pkg::bk_sector_bits-1:0] sector,
	output logic                              last
);

	import bk_pkg::*;

	// Index register
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sector <= '0;
		end else if (clear) begin
			sector <= '0;              // New transfer starts at sector 0
		end else if (advance) begin
			sector <= sector + 1'b1;
		end
	end

	// High for the whole of the final sector
	assign last = (sector == bk_sector_bits'(bk_last_sector));

endmodule

//--- logic/bk_sequencer.sv
/*
 Runs one load or save of every sector, one request per sector.
 sd_rd and sd_wr are levels held until the host raises sd_ack.
 Requests seen while busy are dropped, not queued.
 clear and advance are combinational and act on the counter at the
 same edge the strobes change.
*/

module bk_sequencer (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        load_req,
	input  logic        save_req,
	input  logic        cart_download,
	input  logic        sd_ack,
	input  logic [63:0] img_size,
	input  logic        save_enabled,
	input  logic        last,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        busy,
	output logic        loading,
	output logic        clear,
	output logic        advance
);

	logic load_lvl;
	logic save_lvl;
	logic load_q;
	logic save_q;
	logic dl_q;
	logic ack_q;

	logic load_edge;
	logic save_edge;
	logic dl_end;
	logic ack_rise;
	logic ack_fall;
	logic start;
	logic start_load;

	// ====================
	// Edge detection
	// ====================
	assign load_lvl = load_req & save_enabled;   // Requests only count when armed
	assign save_lvl = save_req & save_enabled;

	assign load_edge = load_lvl & ~load_q;
	assign save_edge = save_lvl & ~save_q;
	assign dl_end    = dl_q & ~cart_download & (|img_size) & save_enabled;
	assign ack_rise  = sd_ack & ~ack_q;
	assign ack_fall  = ~sd_ack & ack_q;

	// Download end always means load
	assign start      = load_edge | save_edge | dl_end;
	assign start_load = load_edge | dl_end;

	// Counter control
	assign clear   = ~busy & start;
	assign advance = busy & ack_fall & ~last;

	// ====================
	// Idle / transfer FSM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			loading <= 1'b0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
			load_q  <= 1'b0;
			save_q  <= 1'b0;
			dl_q    <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			load_q <= load_lvl;
			save_q <= save_lvl;
			dl_q   <= cart_download;
			ack_q  <= sd_ack;

			// Host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!busy) begin
				if (start) begin
					busy    <= 1'b1;
					loading <= start_load;
					sd_rd   <= start_load;
					sd_wr   <= ~start_load;
				end
			end else if (ack_fall) begin
				if (last) begin
					busy    <= 1'b0;     // All sectors moved
					loading <= 1'b0;
				end else begin
					// Ask for the next sector, same direction
					sd_rd <= loading;
					sd_wr <= ~loading;
				end
			end
		end
	end

endmodule

//--- logic/bk_dirty_tracker.sv
/*
 Save arming and dirty tracking.
 Saving is armed only when a writable image is mounted while a
 cartridge is downloading; a new download disarms it first.
 Writes made with the menu open are not counted as dirty.
*/

module bk_dirty_tracker (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic cart_download,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic nv_we,
	input  logic osd_open,
	input  logic autosave_en,
	input  logic busy,
	output logic save_enabled,
	output logic pending,
	output logic autosave_req
);

	logic dl_q;
	logic dl_rise;

	assign dl_rise = cart_download & ~dl_q;

	// ====================
	// Save enable
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_q         <= 1'b0;
			save_enabled <= 1'b0;
		end else begin
			dl_q <= cart_download;
			if (dl_rise)
				save_enabled <= 1'b0;   // New cartridge, old save no longer valid
			// Host mounts the save file near the end of the download
			if (cart_download && img_mounted && !img_readonly)
				save_enabled <= 1'b1;
		end
	end

	// Pending write flag
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (save_enabled && !osd_open && nv_we) begin
			pending <= 1'b1;
		end else if (busy) begin
			pending <= 1'b0;            // Any transfer syncs RAM and file
		end
	end

	assign autosave_req = pending & osd_open & autosave_en;

endmodule

//--- logic/bk_nvram.sv
/*
 32 KiB true dual-port backup RAM, no reset on contents.
 Both ports read with one cycle of latency.
 Host writes land only while sd_ack is high.
*/

module bk_nvram (
	input  logic                              clk_sys,
	input  bk_pkg::bk_addr_u                  nv_addr,
	input  logic                              nv_we,
	input  bk_pkg::bk_byte_t                  nv_wdata,
	output bk_pkg::bk_byte_t                  nv_rdata,
	input  logic [bk_pkg::bk_sector_bits-1:0] sector,
	input  logic [bk_pkg::bk_offset_bits-1:0] sd_buff_addr,
	input  logic                              sd_buff_wr,
	input  logic                              sd_ack,
	input  bk_pkg::bk_byte_t                  sd_buff_dout,
	output bk_pkg::bk_byte_t                  sd_buff_din
);

	import bk_pkg::*;

	bk_byte_t mem [0:(2 ** bk_addr_bits)-1];
	bk_addr_u host_addr;

	// Host address is the sector being moved plus the buffer offset
	always_comb begin
		host_addr.host.sector = sector;
		host_addr.host.offset = sd_buff_addr;
	end

	// ==================== Console port
	always @(posedge clk_sys) begin
		if (nv_we)
			mem[nv_addr.flat] <= nv_wdata;
		nv_rdata <= mem[nv_addr.flat];
	end

	// ==================== Host port
	always @(posedge clk_sys) begin
		if (sd_buff_wr && sd_ack)
			mem[host_addr.flat] <= sd_buff_dout;
		sd_buff_din <= mem[host_addr.flat];   // Feeds save transfers
	end

endmodule

//--- logic/bk_store.sv
/*
 Backup RAM subsystem top level.
 sd_lba only ever spans sectors 0 to 63 of the save file.
 The console must hold off RAM access while loading is high.
*/

module bk_store (
	input  logic                              clk_sys,
	input  logic                              rst_n,

	// Console port
	input  bk_pkg::bk_addr_u                  nv_addr,
	input  logic                              nv_we,
	input  bk_pkg::bk_byte_t                  nv_wdata,
	output bk_pkg::bk_byte_t                  nv_rdata,

	// Control
	input  logic                              load_req,
	input  logic                              save_req,
	input  logic                              osd_open,
	input  logic                              autosave_en,
	input  logic                              cart_download,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic [63:0]                       img_size,

	// Host sector interface
	output logic [31:0]                       sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	input  logic                              sd_ack,
	input  logic [bk_pkg::bk_offset_bits-1:0] sd_buff_addr,
	input  bk_pkg::bk_byte_t                  sd_buff_dout,
	output bk_pkg::bk_byte_t                  sd_buff_din,
	input  logic                              sd_buff_wr,

	// Status
	output logic                              busy,
	output logic                              loading,
	output logic                              pending
);

	import bk_pkg::*;

	logic [bk_sector_bits-1:0] sector;
	logic                      last;
	logic                      clear;
	logic                      advance;
	logic                      save_enabled;
	logic                      autosave_req;
	logic                      save_any;

	assign save_any = save_req | autosave_req;   // Menu autosave acts as a save request
	assign sd_lba   = {{(32 - bk_sector_bits){1'b0}}, sector};

	// ====================
	// Transfer control
	// ====================
	bk_sector_counter u_counter (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.clear   (clear),
		.advance (advance),
		.sector  (sector),
		.last    (last)
	);

	bk_sequencer u_sequencer (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.load_req      (load_req),
		.save_req      (save_any),
		.cart_download (cart_download),
		.sd_ack        (sd_ack),
		.img_size      (img_size),
		.save_enabled  (save_enabled),
		.last          (last),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.busy          (busy),
		.loading       (loading),
		.clear         (clear),
		.advance       (advance)
	);

	bk_dirty_tracker u_dirty (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.nv_we         (nv_we),
		.osd_open      (osd_open),
		.autosave_en   (autosave_en),
		.busy          (busy),
		.save_enabled  (save_enabled),
		.pending       (pending),
		.autosave_req  (autosave_req)
	);

	// ====================
	// Storage
	// ====================
	bk_nvram u_nvram (
		.clk_sys      (clk_sys),
		.nv_addr      (nv_addr),
		.nv_we        (nv_we),
		.nv_wdata     (nv_wdata),
		.nv_rdata     (nv_rdata),
		.sector       (sector),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_wr   (sd_buff_wr),
		.sd_ack       (sd_ack),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_din  (sd_buff_din)
	);

endmodule

//--- verification/bk_store_properties.sv
/*
 Sequencer protocol checks, bound into every bk_sequencer instance.
 violations counts assertion failures so the testbench can add them
 to its own error count.
*/

module bk_store_properties (
	input logic clk_sys,
	input logic rst_n,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack,
	input logic busy,
	input logic last,
	input logic advance
);

	int violations = 0;

	// ====================
	// Strobes
	// ====================
	strobe_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(sd_rd && sd_wr))
	else begin
		violations++;
		$error("sd_rd and sd_wr are high together");
	end

	strobe_in_transfer: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(sd_rd || sd_wr) |-> busy)
	else begin
		violations++;
		$error("sector strobe raised while not busy");
	end

	// A missed clear leaves the counter on sector 63 and last high
	start_on_sector0: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(busy) |-> !last)
	else begin
		violations++;
		$error("transfer started on a sector other than 0");
	end

	// Next sector only once the strobe was taken and sd_ack has gone
	advance_on_ack_fall: assert property (@(posedge clk_sys) disable iff (!rst_n)
		advance |-> (!sd_ack && $past(sd_ack) && !sd_rd && !sd_wr))
	else begin
		violations++;
		$error("sector advanced without a falling edge of sd_ack");
	end

endmodule

bind bk_sequencer bk_store_properties u_props (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.sd_rd   (sd_rd),
	.sd_wr   (sd_wr),
	.sd_ack  (sd_ack),
	.busy    (busy),
	.last    (last),
	.advance (advance)
);

//--- verification/bk_store_tb.sv
/*
 Testbench for the backup RAM subsystem.
 A behavioural host answers every sector request; load data come from
 an LCG stream. Tests run in order and share the RAM contents.
*/

module bk_store_tb;

	import bk_pkg::*;

	localparam int mem_bytes      = 2 ** bk_addr_bits;
	localparam int sector_bytes   = 2 ** bk_offset_bits;
	localparam int timeout_cycles = 6 * 64 * 560 + 40000;

	logic                      clk_sys;
	logic                      rst_n;
	bk_addr_u                  nv_addr;
	logic                      nv_we;
	bk_byte_t                  nv_wdata;
	bk_byte_t                  nv_rdata;
	logic                      load_req;
	logic                      save_req;
	logic                      osd_open;
	logic                      autosave_en;
	logic                      cart_download;
	logic                      img_mounted;
	logic                      img_readonly;
	logic [63:0]               img_size;
	logic [31:0]               sd_lba;
	logic                      sd_rd;
	logic                      sd_wr;
	logic                      sd_ack;
	logic [bk_offset_bits-1:0] sd_buff_addr;
	bk_byte_t                  sd_buff_dout;
	bk_byte_t                  sd_buff_din;
	logic                      sd_buff_wr;
	logic                      busy;
	logic                      loading;
	logic                      pending;

	bk_byte_t    load_image [0:mem_bytes-1];   // Stream the host serves
	bk_byte_t    save_image [0:mem_bytes-1];   // What the host captured
	int unsigned sector_log [$];
	int unsigned rng;
	int          error_count;
	int          errors_before;
	int          tests_run;
	int          tests_failed;
	int          cycle_count;

	bk_store u_dut (.*);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count == timeout_cycles) begin
			$display("Timeout: run did not end within %0d cycles", timeout_cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic int unsigned lcg_next(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Depends on all 15 address bits
	function automatic bk_byte_t console_byte(input logic [14:0] addr);
		return addr[7:0] ^ {addr[14:8], 1'b1};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("Mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual);
		error_count++;
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		error_count++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (error_count != errors_before)
			tests_failed++;
		$display("Test %0d %s: %s", tests_run, name,
			(error_count == errors_before) ? "pass" : "FAIL");
		errors_before = error_count;
	endtask

	task automatic expect_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk_sys);
			assert (!busy) else report_mismatch("busy", 0, busy);
			assert (!sd_rd && !sd_wr) else report_mismatch("sd_rd/sd_wr", 0, {sd_rd, sd_wr});
		end
	endtask

	task automatic pulse_requests();
		load_req <= 1'b1;
		@(posedge clk_sys);
		load_req <= 1'b0;
		@(posedge clk_sys);
		save_req <= 1'b1;
		@(posedge clk_sys);
		save_req <= 1'b0;
	endtask

	// Host mounts the image in the middle of the download
	task automatic download(input logic mount, input logic readonly, input logic [63:0] size);
		cart_download <= 1'b1;
		repeat (4) @(posedge clk_sys);
		img_readonly <= readonly;
		img_size     <= size;
		img_mounted  <= mount;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		repeat (4) @(posedge clk_sys);
		cart_download <= 1'b0;
	endtask

	task automatic run_transfer();
		while (!busy)
			@(posedge clk_sys);
		while (busy)
			@(posedge clk_sys);
	endtask

	// ====================
	// Host sector model
	// ====================
	task automatic serve_sector(input logic is_load, input logic [bk_sector_bits-1:0] sector);
		int base;
		base = int'(sector) * sector_bytes;
		sector_log.push_back(sector);
		repeat (2) @(posedge clk_sys);
		sd_ack <= 1'b1;
		for (int k = 0; k < sector_bytes + 2; k++) begin
			@(posedge clk_sys);
			if (!is_load && k >= 2)
				save_image[base + k - 2] = sd_buff_din;   // Two edges behind the address
			if (k < sector_bytes) begin
				sd_buff_addr <= k[8:0];
				sd_buff_dout <= load_image[base + k];
			end
			sd_buff_wr <= is_load && (k < sector_bytes);
		end
		@(posedge clk_sys);
		sd_ack <= 1'b0;
	endtask

	always begin
		@(posedge clk_sys);
		if (rst_n && (sd_rd || sd_wr))
			serve_sector(sd_rd, sd_lba[bk_sector_bits-1:0]);
	end

	// ====================
	// Test sequence
	// ====================
	initial begin
		int unsigned addr;
		bk_byte_t    data;
		int          property_errors;

		clk_sys       = 1'b0;
		rst_n         = 1'b0;
		nv_addr       = '0;
		nv_we         = 1'b0;
		nv_wdata      = '0;
		load_req      = 1'b0;
		save_req      = 1'b0;
		osd_open      = 1'b0;
		autosave_en   = 1'b0;
		cart_download = 1'b0;
		img_mounted   = 1'b0;
		img_readonly  = 1'b0;
		img_size      = '0;
		sd_ack        = 1'b0;
		sd_buff_addr  = '0;
		sd_buff_dout  = '0;
		sd_buff_wr    = 1'b0;
		error_count   = 0;
		errors_before = 0;
		tests_run     = 0;
		tests_failed  = 0;
		cycle_count   = 0;
		rng           = 71579;
		for (int a = 0; a < mem_bytes; a++) begin
			rng = lcg_next(rng);
			load_image[a] = rng[23:16];
		end

		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);

		pulse_requests();
		expect_idle(4);
		finish_test("requests without an image");

		download(1'b1, 1'b1, 64'd32768);
		expect_idle(4);
		pulse_requests();
		expect_idle(4);
		finish_test("read-only image");

		download(1'b1, 1'b0, 64'd0);
		expect_idle(4);   // Empty save file, no autoload
		download(1'b1, 1'b0, 64'd32768);
		repeat (2) @(posedge clk_sys);
		assert (busy && loading && sd_rd)
			else report_mismatch("busy/loading/sd_rd", 3'b111, {busy, loading, sd_rd});
		assert (sd_lba == 0) else report_mismatch("sd_lba", 0, sd_lba);
		while (busy)
			@(posedge clk_sys);
		finish_test("autoload at download end");

		for (int a = 0; a < mem_bytes; a++) begin
			nv_addr  <= a[14:0];
			nv_we    <= 1'b1;
			nv_wdata <= console_byte(a[14:0]);
			@(posedge clk_sys);
		end
		nv_we <= 1'b0;
		sector_log.delete();
		save_req <= 1'b1;
		@(posedge clk_sys);
		save_req <= 1'b0;
		run_transfer();
		if (sector_log.size() != 64)
			report_failure($sformatf("Save moved %0d sectors instead of 64", sector_log.size()));
		foreach (sector_log[i])
			assert (sector_log[i] == i) else report_mismatch("sd_lba", i, sector_log[i]);
		for (int a = 0; a < mem_bytes; a++) begin
			assert (save_image[a] == console_byte(a[14:0]))
				else report_mismatch($sformatf("sd_buff_din[0x%0h]", a),
					console_byte(a[14:0]), save_image[a]);
		end
		finish_test("manual save");

		load_req <= 1'b1;
		@(posedge clk_sys);
		load_req <= 1'b0;
		run_transfer();
		repeat (64) begin
			rng  = lcg_next(rng);
			addr = rng[30:16];
			nv_addr <= addr[14:0];
			repeat (2) @(posedge clk_sys);
			assert (nv_rdata == load_image[addr])
				else report_mismatch($sformatf("nv_rdata[0x%0h]", addr), load_image[addr], nv_rdata);
		end
		finish_test("manual load");

		addr = 32'h4321;
		data = ~console_byte(addr[14:0]);
		assert (!pending) else report_mismatch("pending", 0, pending);
		nv_addr  <= addr[14:0];
		nv_wdata <= data;
		nv_we    <= 1'b1;
		@(posedge clk_sys);
		nv_we <= 1'b0;
		@(posedge clk_sys);
		assert (pending) else report_mismatch("pending", 1, pending);
		osd_open    <= 1'b1;
		autosave_en <= 1'b1;
		run_transfer();
		assert (!pending) else report_mismatch("pending", 0, pending);
		assert (save_image[addr] == data)
			else report_mismatch("sd_buff_din", data, save_image[addr]);
		osd_open    <= 1'b0;
		autosave_en <= 1'b0;
		finish_test("menu autosave");

		property_errors = u_dut.u_sequencer.u_props.violations;
		$display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, error_count, property_errors);
		if (error_count == 0 && property_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- project.f
logic/bk_pkg.sv
logic/bk_sector_counter.sv
logic/bk_sequencer.sv
logic/bk_dirty_tracker.sv
logic/bk_nvram.sv
logic/bk_store.sv
verification/bk_store_properties.sv
verification/bk_store_tb.sv

//--- Bender.yml
package:
  name: bk_store

sources:
  - logic/bk_pkg.sv
  - logic/bk_sector_counter.sv
  - logic/bk_sequencer.sv
  - logic/bk_dirty_tracker.sv
  - logic/bk_nvram.sv
  - logic/bk_store.sv
  - target: test
    files:
      - verification/bk_store_properties.sv
      - verification/bk_store_tb.sv
